// ==== hw/pagerank_settings.svh ====
`ifndef PAGERANK_SETTINGS_SVH
`define PAGERANK_SETTINGS_SVH

// Graph size
`define PR_NUM_NODES      16
`define PR_NODE_BITS      4

// Stored out-edges per node and the width of a degree count
`define PR_MAX_DEGREE     4
`define PR_DEGREE_BITS    3

// Unsigned fixed point, one unit is 2**PR_FRAC_BITS
`define PR_RANK_BITS      32
`define PR_FRAC_BITS      24

// Damping is a pure fraction of 2**PR_DAMP_BITS
`define PR_DAMP_BITS      16

// Iteration cap
`define PR_MAX_ITERATIONS 500
`define PR_ITER_BITS      10

`endif

// ==== hw/pagerank_pkg.sv ====
`include "pagerank_settings.svh"

package pagerank_pkg;

    // Node index
    typedef logic [`PR_NODE_BITS-1:0] node_id_t;

    // Out-degree count, holds 0 to PR_MAX_DEGREE
    typedef logic [`PR_DEGREE_BITS-1:0] degree_t;

    // Fixed-point rank, also used for shares, sums, delta and threshold
    typedef logic [`PR_RANK_BITS-1:0] rank_t;

    // Damping factor as a fraction
    typedef logic [`PR_DAMP_BITS-1:0] damp_t;

    // Iteration count
    typedef logic [`PR_ITER_BITS-1:0] iter_t;

    // One directed edge of the graph
    typedef struct packed {
        node_id_t src;
        node_id_t dst;
    } edge_t;

    // Share of a source rank headed for one destination
    typedef struct packed {
        node_id_t dst;
        rank_t    share;
    } contribution_t;

endpackage

// ==== hw/graph_store.sv ====
`include "pagerank_settings.svh"

module graph_store
    import pagerank_pkg::*;
(
    input  logic     clock,
    input  logic     reset_n,
    input  logic     edge_valid,
    input  edge_t    edge_in,
    input  node_id_t degree_node,
    output degree_t  degree,
    input  node_id_t edge_node,
    input  degree_t  edge_slot,
    output node_id_t edge_dst
);

    localparam int SLOT_BITS = $clog2(`PR_MAX_DEGREE);

    node_id_t dst_mem    [`PR_NUM_NODES][`PR_MAX_DEGREE];
    degree_t  degree_mem [`PR_NUM_NODES];
    logic     slot_free;
    logic     edge_write;

    // Edges past the per-node limit are dropped
    assign slot_free  = degree_mem[edge_in.src] < degree_t'(`PR_MAX_DEGREE);
    assign edge_write = edge_valid && slot_free;

    always_ff @(posedge clock, negedge reset_n) begin
        if (!reset_n) begin
            for (int n = 0; n < `PR_NUM_NODES; n++) begin
                degree_mem[n] <= '0;
            end
        end else if (edge_write) begin
            degree_mem[edge_in.src] <= degree_mem[edge_in.src] + degree_t'(1);
        end
    end

    // Next free slot of the source is its current degree
    always_ff @(posedge clock) begin
        if (edge_write) begin
            dst_mem[edge_in.src][degree_mem[edge_in.src][SLOT_BITS-1:0]] <= edge_in.dst;
        end
    end

    assign degree   = degree_mem[degree_node];
    assign edge_dst = dst_mem[edge_node][edge_slot[SLOT_BITS-1:0]];

endmodule

// ==== hw/rank_scatter.sv ====
`include "pagerank_settings.svh"

module rank_scatter
    import pagerank_pkg::*;
(
    input  logic          clock,
    input  logic          reset_n,
    input  logic          start,
    input  logic          next_iteration,
    output node_id_t      degree_node,
    input  degree_t       degree,
    output node_id_t      edge_node,
    output degree_t       edge_slot,
    input  node_id_t      edge_dst,
    output node_id_t      share_node,
    input  rank_t         share_rank,
    output logic          contrib_valid,
    output contribution_t contrib,
    output logic          scatter_done
);

    typedef enum logic [1:0] {IDLE, LOAD_SHARE, EMIT, DONE} state_t;

    localparam node_id_t LAST_NODE = node_id_t'(`PR_NUM_NODES - 1);

    state_t   state;
    node_id_t node_cnt;
    degree_t  edge_cnt;
    rank_t    share_reg;
    logic     last_node;
    logic     last_edge;

    assign last_node = node_cnt == LAST_NODE;
    // Only looked at in EMIT, where the degree is nonzero
    assign last_edge = edge_cnt == degree - degree_t'(1);

    always_ff @(posedge clock, negedge reset_n) begin
        if (!reset_n) begin
            state    <= IDLE;
            node_cnt <= '0;
            edge_cnt <= '0;
        end else if (start || next_iteration) begin
            state    <= LOAD_SHARE;
            node_cnt <= '0;
            edge_cnt <= '0;
        end else begin
            case (state)
                LOAD_SHARE: begin
                    edge_cnt <= '0;
                    if (degree != '0) begin
                        state <= EMIT;
                    end else if (last_node) begin
                        state <= DONE;
                    end else begin
                        node_cnt <= node_cnt + node_id_t'(1);
                    end
                end
                EMIT: begin
                    if (!last_edge) begin
                        edge_cnt <= edge_cnt + degree_t'(1);
                    end else if (last_node) begin
                        state <= DONE;
                    end else begin
                        node_cnt <= node_cnt + node_id_t'(1);
                        state    <= LOAD_SHARE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Dangling nodes skip the divide and send nothing
    always_ff @(posedge clock) begin
        if (state == LOAD_SHARE && degree != '0) begin
            share_reg <= share_rank / rank_t'(degree);
        end
    end

    assign degree_node   = node_cnt;
    assign share_node    = node_cnt;
    assign edge_node     = node_cnt;
    assign edge_slot     = edge_cnt;
    assign contrib_valid = state == EMIT;
    assign contrib.dst   = edge_dst;
    assign contrib.share = share_reg;
    assign scatter_done  = state == DONE;

endmodule

// ==== hw/rank_accumulator.sv ====
`include "pagerank_settings.svh"

module rank_accumulator
    import pagerank_pkg::*;
(
    input  logic          clock,
    input  logic          reset_n,
    input  logic          start,
    input  logic          next_iteration,
    input  logic          contrib_valid,
    input  contribution_t contrib,
    input  logic          scatter_done,
    input  node_id_t      sum_node,
    output rank_t         sum_data,
    output logic          sums_valid
);

    rank_t sums [`PR_NUM_NODES];

    // One add per cycle, sums restart with every scatter pass
    always_ff @(posedge clock) begin
        if (start || next_iteration) begin
            for (int n = 0; n < `PR_NUM_NODES; n++) begin
                sums[n] <= '0;
            end
        end else if (contrib_valid) begin
            sums[contrib.dst] <= sums[contrib.dst] + contrib.share;
        end
    end

    // Last add lands together with this flag
    always_ff @(posedge clock, negedge reset_n) begin
        if (!reset_n) begin
            sums_valid <= 1'b0;
        end else begin
            sums_valid <= scatter_done;
        end
    end

    assign sum_data = sums[sum_node];

endmodule

// ==== hw/rank_update.sv ====
`include "pagerank_settings.svh"

module rank_update
    import pagerank_pkg::*;
(
    input  logic     clock,
    input  logic     reset_n,
    input  logic     start,
    input  damp_t    damping,
    input  rank_t    threshold,
    input  logic     sums_valid,
    output node_id_t sum_node,
    input  rank_t    sum_data,
    input  node_id_t share_node,
    output rank_t    share_rank,
    input  node_id_t rank_addr,
    output rank_t    rank_data,
    output logic     next_iteration,
    output logic     complete,
    output iter_t    iteration_count
);

    typedef enum logic [1:0] {WAIT_SUMS, SWEEP, DECIDE, DONE} state_t;

    localparam node_id_t LAST_NODE = node_id_t'(`PR_NUM_NODES - 1);
    localparam rank_t    INIT_RANK = rank_t'((64'd1 << `PR_FRAC_BITS) / `PR_NUM_NODES);
    localparam iter_t    MAX_ITER  = iter_t'(`PR_MAX_ITERATIONS);

    state_t   state;
    node_id_t node_cnt;
    iter_t    iter_cnt;
    rank_t    delta;
    rank_t    ranks [`PR_NUM_NODES];

    logic [`PR_DAMP_BITS:0]                one_minus_damp;
    logic [63:0]                           base_num;
    rank_t                                 base;
    logic [`PR_DAMP_BITS+`PR_RANK_BITS-1:0] damped_sum;
    rank_t                                 new_rank;
    rank_t                                 old_rank;
    rank_t                                 rank_diff;
    logic                                  stop;

    // Base term (1 - d) / N in rank units
    assign one_minus_damp = {1'b1, {`PR_DAMP_BITS{1'b0}}} - {1'b0, damping};
    assign base_num       = 64'(one_minus_damp) << `PR_FRAC_BITS;
    assign base           = rank_t'(base_num / (64'(`PR_NUM_NODES) << `PR_DAMP_BITS));

    assign damped_sum = damping * sum_data;
    assign new_rank   = base + rank_t'(damped_sum >> `PR_DAMP_BITS);
    assign old_rank   = ranks[node_cnt];
    assign rank_diff  = (new_rank >= old_rank) ? new_rank - old_rank : old_rank - new_rank;

    // Counter already holds this sweep
    assign stop = (delta < threshold) || (iter_cnt >= MAX_ITER);

    always_ff @(posedge clock, negedge reset_n) begin
        if (!reset_n) begin
            state    <= WAIT_SUMS;
            node_cnt <= '0;
            iter_cnt <= '0;
            delta    <= '0;
            for (int n = 0; n < `PR_NUM_NODES; n++) begin
                ranks[n] <= '0;
            end
        end else if (start) begin
            state    <= WAIT_SUMS;
            node_cnt <= '0;
            iter_cnt <= '0;
            delta    <= '0;
            for (int n = 0; n < `PR_NUM_NODES; n++) begin
                ranks[n] <= INIT_RANK;
            end
        end else begin
            case (state)
                WAIT_SUMS: begin
                    if (sums_valid) begin
                        node_cnt <= '0;
                        delta    <= '0;
                        state    <= SWEEP;
                    end
                end
                SWEEP: begin
                    ranks[node_cnt] <= new_rank;
                    delta           <= delta + rank_diff;
                    if (node_cnt == LAST_NODE) begin
                        iter_cnt <= iter_cnt + iter_t'(1);
                        state    <= DECIDE;
                    end else begin
                        node_cnt <= node_cnt + node_id_t'(1);
                    end
                end
                DECIDE: begin
                    state <= stop ? DONE : WAIT_SUMS;
                end
                default: begin
                    // Held until the next start
                    state <= DONE;
                end
            endcase
        end
    end

    assign sum_node        = node_cnt;
    assign share_rank      = ranks[share_node];
    assign rank_data       = ranks[rank_addr];
    assign next_iteration  = (state == DECIDE) && !stop;
    assign complete        = (state == DONE) || ((state == DECIDE) && stop);
    assign iteration_count = iter_cnt;

endmodule

// ==== hw/pagerank_top.sv ====
`include "pagerank_settings.svh"

module pagerank_top
    import pagerank_pkg::*;
(
    input  logic     clock,
    input  logic     reset_n,
    input  logic     edge_valid,
    input  edge_t    edge_in,
    input  logic     start,
    input  damp_t    damping,
    input  rank_t    threshold,
    input  node_id_t rank_addr,
    output rank_t    rank_data,
    output logic     complete,
    output iter_t    iteration_count
);

    // Graph read port
    node_id_t degree_node;
    degree_t  degree;
    node_id_t edge_node;
    degree_t  edge_slot;
    node_id_t edge_dst;

    // Rank read by the scatter engine
    node_id_t share_node;
    rank_t    share_rank;

    // Scatter to gather
    logic          contrib_valid;
    contribution_t contrib;
    logic          scatter_done;

    // Gather to update
    logic     sums_valid;
    node_id_t sum_node;
    rank_t    sum_data;
    logic     next_iteration;

    graph_store u_graph_store (
        .clock       (clock),
        .reset_n     (reset_n),
        .edge_valid  (edge_valid),
        .edge_in     (edge_in),
        .degree_node (degree_node),
        .degree      (degree),
        .edge_node   (edge_node),
        .edge_slot   (edge_slot),
        .edge_dst    (edge_dst)
    );

    rank_scatter u_rank_scatter (
        .clock          (clock),
        .reset_n        (reset_n),
        .start          (start),
        .next_iteration (next_iteration),
        .degree_node    (degree_node),
        .degree         (degree),
        .edge_node      (edge_node),
        .edge_slot      (edge_slot),
        .edge_dst       (edge_dst),
        .share_node     (share_node),
        .share_rank     (share_rank),
        .contrib_valid  (contrib_valid),
        .contrib        (contrib),
        .scatter_done   (scatter_done)
    );

    rank_accumulator u_rank_accumulator (
        .clock          (clock),
        .reset_n        (reset_n),
        .start          (start),
        .next_iteration (next_iteration),
        .contrib_valid  (contrib_valid),
        .contrib        (contrib),
        .scatter_done   (scatter_done),
        .sum_node       (sum_node),
        .sum_data       (sum_data),
        .sums_valid     (sums_valid)
    );

    rank_update u_rank_update (
        .clock           (clock),
        .reset_n         (reset_n),
        .start           (start),
        .damping         (damping),
        .threshold       (threshold),
        .sums_valid      (sums_valid),
        .sum_node        (sum_node),
        .sum_data        (sum_data),
        .share_node      (share_node),
        .share_rank      (share_rank),
        .rank_addr       (rank_addr),
        .rank_data       (rank_data),
        .next_iteration  (next_iteration),
        .complete        (complete),
        .iteration_count (iteration_count)
    );

endmodule

// ==== tests/pagerank_props.sv ====
module pagerank_props
    import pagerank_pkg::*;
(
    input logic clock,
    input logic reset_n,
    input logic start,
    input logic complete,
    input logic next_iteration,
    input logic contrib_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    int error_count = 0;

    // A new run clears the done level
    assert property (@(posedge clock) disable iff (!reset_n)
        start |=> !complete)
    else begin
        error_count++;
        $error("complete still high after start");
    end

    assert property (@(posedge clock) disable iff (!reset_n)
        !(contrib_valid && complete))
    else begin
        error_count++;
        $error("contribution sent while complete is high");
    end

    // Done level stays up until a new run
    assert property (@(posedge clock) disable iff (!reset_n)
        complete && !start |=> complete)
    else begin
        error_count++;
        $error("complete dropped without a start");
    end

    assert property (@(posedge clock) disable iff (!reset_n)
        !(next_iteration && complete))
    else begin
        error_count++;
        $error("next_iteration and complete high together");
    end

endmodule

bind pagerank_top pagerank_props u_pagerank_props (
    .clock          (clock),
    .reset_n        (reset_n),
    .start          (start),
    .complete       (complete),
    .next_iteration (next_iteration),
    .contrib_valid  (contrib_valid)
);

// ==== tests/pagerank_tb.sv ====
`include "pagerank_settings.svh"

module pagerank_tb
    import pagerank_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int     NUM_TESTS   = 8;
    localparam longint TEST_CYCLES = (`PR_MAX_ITERATIONS + 1) *
        (2 * `PR_NUM_NODES + `PR_NUM_NODES * `PR_MAX_DEGREE + 8);
    localparam longint WATCHDOG_NS = NUM_TESTS * TEST_CYCLES * 8;
    localparam rank_t  INIT_RANK   = rank_t'((64'd1 << `PR_FRAC_BITS) / `PR_NUM_NODES);

    logic     clock;
    logic     reset_n;
    logic     edge_valid;
    edge_t    edge_in;
    logic     start;
    damp_t    damping;
    rank_t    threshold;
    node_id_t rank_addr;
    rank_t    rank_data;
    logic     complete;
    iter_t    iteration_count;

    integer   seed;

    // Reference model state
    degree_t  model_deg  [`PR_NUM_NODES];
    node_id_t model_dst  [`PR_NUM_NODES][`PR_MAX_DEGREE];
    rank_t    model_rank [`PR_NUM_NODES];
    iter_t    model_iter;

    pagerank_top u_pagerank_top (
        .clock           (clock),
        .reset_n         (reset_n),
        .edge_valid      (edge_valid),
        .edge_in         (edge_in),
        .start           (start),
        .damping         (damping),
        .threshold       (threshold),
        .rank_addr       (rank_addr),
        .rank_data       (rank_data),
        .complete        (complete),
        .iteration_count (iteration_count)
    );

    always #4 clock = ~clock;

    task automatic check_rank(input string name, input rank_t expected, input rank_t actual);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1, "rank mismatch");
        end
    endtask

    task automatic check_iter(input string name, input iter_t expected, input iter_t actual);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1, "iteration count mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1, "flag mismatch");
        end
    endtask

    // Fresh graph, all ranks back to zero
    task automatic apply_reset();
        @(posedge clock);
        #1;
        reset_n = 1'b0;
        repeat (5) @(posedge clock);
        #1;
        reset_n = 1'b1;
        for (int n = 0; n < `PR_NUM_NODES; n++) begin
            model_deg[n]  = '0;
            model_rank[n] = '0;
        end
    endtask

    task automatic load_edge(input node_id_t src, input node_id_t dst);
        @(posedge clock);
        #1;
        edge_valid  = 1'b1;
        edge_in.src = src;
        edge_in.dst = dst;
        // Extra edges of a full node are ignored
        if (model_deg[src] < degree_t'(`PR_MAX_DEGREE)) begin
            model_dst[src][model_deg[src]] = dst;
            model_deg[src] = model_deg[src] + degree_t'(1);
        end
        @(posedge clock);
        #1;
        edge_valid = 1'b0;
    endtask

    task automatic load_random_graph(input int max_edges);
        int count;
        for (int n = 0; n < `PR_NUM_NODES; n++) begin
            count = $unsigned($random(seed)) % (max_edges + 1);
            for (int k = 0; k < count; k++) begin
                load_edge(node_id_t'(n), node_id_t'($random(seed)));
            end
        end
    endtask

    function automatic damp_t random_damping();
        return damp_t'(32'h4000 + $unsigned($random(seed)) % 32'h8000);
    endfunction

    function automatic rank_t random_threshold();
        return rank_t'(32'h0800 + $unsigned($random(seed)) % 32'h0800);
    endfunction

    // Synchronous sweeps in integer fixed point
    task automatic model_run(input damp_t damp, input rank_t thresh);
        rank_t sums      [`PR_NUM_NODES];
        rank_t next_rank [`PR_NUM_NODES];
        rank_t base;
        rank_t share;
        rank_t delta;
        logic  done;
        base = rank_t'((((64'd1 << `PR_DAMP_BITS) - 64'(damp)) << `PR_FRAC_BITS)
                       / (64'(`PR_NUM_NODES) << `PR_DAMP_BITS));
        for (int n = 0; n < `PR_NUM_NODES; n++) begin
            model_rank[n] = INIT_RANK;
        end
        model_iter = '0;
        done       = 1'b0;
        while (!done) begin
            for (int n = 0; n < `PR_NUM_NODES; n++) begin
                sums[n] = '0;
            end
            for (int n = 0; n < `PR_NUM_NODES; n++) begin
                if (model_deg[n] != '0) begin
                    share = model_rank[n] / rank_t'(model_deg[n]);
                    for (int s = 0; s < int'(model_deg[n]); s++) begin
                        sums[model_dst[n][s]] = sums[model_dst[n][s]] + share;
                    end
                end
            end
            delta = '0;
            for (int n = 0; n < `PR_NUM_NODES; n++) begin
                next_rank[n] = base + rank_t'((64'(damp) * 64'(sums[n])) >> `PR_DAMP_BITS);
                if (next_rank[n] >= model_rank[n]) begin
                    delta = delta + (next_rank[n] - model_rank[n]);
                end else begin
                    delta = delta + (model_rank[n] - next_rank[n]);
                end
            end
            for (int n = 0; n < `PR_NUM_NODES; n++) begin
                model_rank[n] = next_rank[n];
            end
            model_iter = model_iter + iter_t'(1);
            done = (delta < thresh) || (model_iter >= iter_t'(`PR_MAX_ITERATIONS));
        end
    endtask

    task automatic check_ranks_against(input rank_t expected [`PR_NUM_NODES]);
        for (int n = 0; n < `PR_NUM_NODES; n++) begin
            @(posedge clock);
            #1;
            rank_addr = node_id_t'(n);
            @(negedge clock);
            check_rank($sformatf("rank_data[%0d]", n), expected[n], rank_data);
        end
    endtask

    task automatic run_and_check(input damp_t damp, input rank_t thresh);
        @(posedge clock);
        #1;
        damping   = damp;
        threshold = thresh;
        start     = 1'b1;
        @(posedge clock);
        #1;
        start = 1'b0;
        @(negedge clock);
        while (!complete) begin
            @(negedge clock);
        end
        model_run(damp, thresh);
        check_iter("iteration_count", model_iter, iteration_count);
        check_ranks_against(model_rank);
    endtask

    initial begin
        rank_t base_ranks [`PR_NUM_NODES];
        clock      = 1'b0;
        reset_n    = 1'b0;
        edge_valid = 1'b0;
        edge_in    = '0;
        start      = 1'b0;
        damping    = '0;
        threshold  = '0;
        rank_addr  = '0;
        seed       = 32'hd17200a6;

        apply_reset();
        @(negedge clock);
        check_flag("complete", 1'b0, complete);
        check_iter("iteration_count", '0, iteration_count);
        check_ranks_against(model_rank);

        repeat (3) begin
            apply_reset();
            load_random_graph(`PR_MAX_DEGREE);
            run_and_check(random_damping(), random_threshold());
        end

        // Same graph again, new damping
        run_and_check(random_damping(), random_threshold());

        apply_reset();
        load_random_graph(7);
        for (int k = 0; k < 5; k++) begin
            load_edge(node_id_t'(0), node_id_t'($random(seed)));
        end
        run_and_check(random_damping(), random_threshold());

        // Zero threshold never converges
        apply_reset();
        load_random_graph(`PR_MAX_DEGREE);
        run_and_check(16'hd999, '0);
        check_iter("iteration_count", iter_t'(`PR_MAX_ITERATIONS), iteration_count);

        // Odd nodes dangle, no damping
        apply_reset();
        for (int n = 0; n < `PR_NUM_NODES; n += 2) begin
            load_edge(node_id_t'(n), node_id_t'(n + 1));
        end
        run_and_check('0, rank_t'(1));
        check_iter("iteration_count", iter_t'(1), iteration_count);
        for (int n = 0; n < `PR_NUM_NODES; n++) begin
            base_ranks[n] = INIT_RANK;
        end
        check_ranks_against(base_ranks);

        if (u_pagerank_top.u_pagerank_props.error_count == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("Bound assertions on the DUT failed during the run");
            $display("CHECKS FAILED");
            $fatal(1, "assertion failures");
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run never completed within %0d ns", WATCHDOG_NS);
        $display("CHECKS FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== verilog.f ====
+incdir+hw
hw/pagerank_pkg.sv
hw/graph_store.sv
hw/rank_scatter.sv
hw/rank_accumulator.sv
hw/rank_update.sv
hw/pagerank_top.sv
tests/pagerank_props.sv
tests/pagerank_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the PageRank testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    --top-module pagerank_tb -Mdir "$BUILD_DIR" -f verilog.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vpagerank_tb" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "ALL CHECKS PASSED" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
